/* design/memGeomPkg.sv */
package memGeomPkg;

    // Data memory.
    localparam int MEM_BYTES = 1024;
    localparam int ADDR_W = 10;

    // Cache geometry, one halfword per line.
    localparam int CACHE_LINES = 64;
    localparam int INDEX_W = 6;
    localparam int TAG_W = 3;

    // Address slicing: bit 0 selects the byte, then index, then tag.
    localparam int INDEX_LSB = 1;
    localparam int TAG_LSB = INDEX_LSB + INDEX_W;

    // Main-memory delay in pipeline stages.
    localparam int MEM_LATENCY = 10;

endpackage

/* design/memOpsPkg.sv */
package memOpsPkg;

    typedef enum logic [1:0] {
        OP_LOAD_HALF  = 2'd0,
        OP_STORE_HALF = 2'd1,
        OP_STORE_BYTE = 2'd2
    } memOp_e;

    // Request from the load/store unit.
    typedef struct packed {
        memOp_e                       op;
        logic [memGeomPkg::ADDR_W-1:0] addr;
        logic [15:0]                  wdata;
        logic [5:0]                   robTag;
    } memReq_t;

    typedef struct packed {
        logic [15:0] rdata;
        logic [5:0]  robTag;
        logic        hit;
    } memResp_t;

    // One access issued into the memory pipeline.
    typedef struct packed {
        logic                         rd;
        logic                         wr;
        logic                         byteWrite; // Store low byte only.
        logic [memGeomPkg::ADDR_W-1:0] addr;
        logic [15:0]                  wdata;
    } memAccess_t;

endpackage

/* design/dataCache.sv */
`timescale 1ns/1ps

module dataCache (
    input  logic               clk,
    input  logic               rstn,
    input  logic               lookup,
    input  memOpsPkg::memReq_t cacheReq,
    input  logic               fill,
    input  logic [15:0]        fillData,
    output logic               cacheHit,
    output logic [15:0]        cacheData
);
    import memOpsPkg::*;
    import memGeomPkg::*;

    logic [TAG_W-1:0]       tagArr [CACHE_LINES];
    logic [15:0]            dataArr [CACHE_LINES];
    logic [CACHE_LINES-1:0] validArr;

    memReq_t          lkReq; // Request of the last lookup.
    logic             lkValid;
    logic [INDEX_W-1:0] reqIdx;
    logic [INDEX_W-1:0] lkIdx;
    logic [TAG_W-1:0] reqTag;
    logic [TAG_W-1:0] lkTag;
    logic             storeHit;
    logic [15:0]      mergedData;

    assign reqIdx = cacheReq.addr[INDEX_LSB +: INDEX_W];
    assign reqTag = cacheReq.addr[TAG_LSB +: TAG_W];
    assign lkIdx = lkReq.addr[INDEX_LSB +: INDEX_W];
    assign lkTag = lkReq.addr[TAG_LSB +: TAG_W];

    // Store that hit in the previous lookup, updated one cycle later.
    assign storeHit = lkValid && cacheHit && (lkReq.op != OP_LOAD_HALF);

    always_comb begin
        mergedData = cacheData;
        if (lkReq.op == OP_STORE_HALF) begin
            mergedData = lkReq.wdata;
        end else if (lkReq.addr[0]) begin
            mergedData[15:8] = lkReq.wdata[7:0]; // Little-endian upper byte.
        end else begin
            mergedData[7:0] = lkReq.wdata[7:0];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            lkValid <= 1'b0;
            cacheHit <= 1'b0;
        end else begin
            lkValid <= lookup;
            if (lookup) begin
                cacheHit <= validArr[reqIdx] && (tagArr[reqIdx] == reqTag);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lookup) begin
            lkReq <= cacheReq;
            cacheData <= dataArr[reqIdx];
        end
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            validArr <= '0;
        end else if (fill) begin
            validArr[lkIdx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (fill) begin
            dataArr[lkIdx] <= fillData;
            tagArr[lkIdx] <= lkTag;
        end else if (storeHit) begin
            dataArr[lkIdx] <= mergedData;
        end
    end

    // Refill only follows a lookup that missed.
    fillAfterMiss: assert property (@(posedge clk) disable iff (!rstn)
        fill |-> !cacheHit && !lkValid)
        else $error("Cache fill targets a line that hit");

endmodule

/* design/dataMemory.sv */
`timescale 1ns/1ps

module dataMemory (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  memIssue,
    input  memOpsPkg::memAccess_t memAccess,
    output logic                  memRdValid,
    output logic [15:0]           memRdData
);
    import memOpsPkg::*;
    import memGeomPkg::*;

    logic [7:0] memArr [MEM_BYTES];

    // Accesses in flight, stage 0 is the newest.
    logic [MEM_LATENCY-1:0] vldPipe;
    memAccess_t             accPipe [MEM_LATENCY];

    memAccess_t        lastAcc;
    logic              lastVld;
    logic [ADDR_W-1:0] hiAddr;

    assign lastAcc = accPipe[MEM_LATENCY-1];
    assign lastVld = vldPipe[MEM_LATENCY-1];
    assign hiAddr = lastAcc.addr + 1'b1;

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            vldPipe <= '0;
        end else begin
            vldPipe <= {vldPipe[MEM_LATENCY-2:0], memIssue};
        end
    end

    always_ff @(posedge clk) begin
        accPipe[0] <= memAccess;
        for (int i = 1; i < MEM_LATENCY; i++) begin
            accPipe[i] <= accPipe[i-1];
        end
    end

    // Last stage performs the access.
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < MEM_BYTES; i++) begin
                memArr[i] <= 8'h00;
            end
            memRdValid <= 1'b0;
        end else begin
            memRdValid <= lastVld && lastAcc.rd;
            if (lastVld && lastAcc.wr) begin
                memArr[lastAcc.addr] <= lastAcc.wdata[7:0];
                if (!lastAcc.byteWrite) begin
                    memArr[hiAddr] <= lastAcc.wdata[15:8];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (lastVld && lastAcc.rd) begin
            memRdData <= {memArr[hiAddr], memArr[lastAcc.addr]}; // Little-endian.
        end
    end

    halfAligned: assert property (@(posedge clk) disable iff (!rstn)
        memIssue && !memAccess.byteWrite |-> !memAccess.addr[0])
        else $error("Unaligned halfword access at %h", memAccess.addr);

endmodule

/* design/memHierarchyCtrl.sv */
`timescale 1ns/1ps

module memHierarchyCtrl (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req,
    input  memOpsPkg::memReq_t    reqData,
    output logic                  ack,
    output memOpsPkg::memResp_t   resp,
    output logic                  lookup,
    output memOpsPkg::memReq_t    cacheReq,
    input  logic                  cacheHit,
    input  logic [15:0]           cacheData,
    output logic                  memIssue,
    output memOpsPkg::memAccess_t memAccess,
    input  logic                  memRdValid,
    input  logic [15:0]           memRdData,
    output logic                  fill
);
    import memOpsPkg::*;

    typedef enum logic [2:0] {
        IDLE,
        LOOKUP,
        MISS_WAIT,
        RESPOND,
        RELEASE
    } ctrlState_e;

    ctrlState_e state;
    memReq_t    reqReg;
    logic       isStore;

    assign isStore = reqReg.op != OP_LOAD_HALF;

    assign lookup = state == LOOKUP;
    assign cacheReq = reqReg;

    // Hit result is valid in RESPOND. Stores post here, hit or not.
    assign memIssue = (state == RESPOND) && (isStore || !cacheHit);
    assign fill = (state == MISS_WAIT) && memRdValid;

    always_comb begin
        memAccess.rd = !isStore;
        memAccess.wr = isStore;
        memAccess.byteWrite = reqReg.op == OP_STORE_BYTE;
        memAccess.addr = reqReg.addr;
        memAccess.wdata = reqReg.wdata;
    end

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            state <= IDLE;
            ack <= 1'b0;
        end else begin
            case (state)
                IDLE: begin
                    if (req) state <= LOOKUP;
                end
                LOOKUP: state <= RESPOND;
                RESPOND: begin
                    if (isStore || cacheHit) begin
                        ack <= 1'b1;
                        state <= RELEASE;
                    end else begin
                        state <= MISS_WAIT;
                    end
                end
                MISS_WAIT: begin
                    if (memRdValid) begin
                        ack <= 1'b1;
                        state <= RELEASE;
                    end
                end
                RELEASE: begin
                    if (!req) begin // Hold ack until requester lets go.
                        ack <= 1'b0;
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == IDLE && req) begin
            reqReg <= reqData;
        end
        if (state == RESPOND) begin
            resp.rdata <= isStore ? 16'h0000 : cacheData;
            resp.robTag <= reqReg.robTag;
            resp.hit <= cacheHit;
        end
        if (fill) begin
            resp.rdata <= memRdData;
            resp.hit <= 1'b0;
        end
    end

    // Requester keeps req up until ack answers.
    reqHeld: assert property (@(posedge clk) disable iff (!rstn)
        req && !ack |=> req || ack)
        else $error("req dropped before ack");

    // Memory reads are only issued for a pending miss.
    rdInMiss: assert property (@(posedge clk) disable iff (!rstn)
        memRdValid |-> state == MISS_WAIT)
        else $error("Memory read data outside a miss wait");

endmodule

/* design/memSubsystem.sv */
`timescale 1ns/1ps

module memSubsystem (
    input  logic                clk,
    input  logic                rstn,
    input  logic                req,
    input  memOpsPkg::memReq_t  reqData,
    output logic                ack,
    output memOpsPkg::memResp_t resp
);
    import memOpsPkg::*;

    logic       lookup;
    memReq_t    cacheReq;
    logic       cacheHit;
    logic [15:0] cacheData;
    logic       fill;
    logic       memIssue;
    memAccess_t memAccess;
    logic       memRdValid;
    logic [15:0] memRdData;

    memHierarchyCtrl u_ctrl (
        .clk        (clk),
        .rstn       (rstn),
        .req        (req),
        .reqData    (reqData),
        .ack        (ack),
        .resp       (resp),
        .lookup     (lookup),
        .cacheReq   (cacheReq),
        .cacheHit   (cacheHit),
        .cacheData  (cacheData),
        .memIssue   (memIssue),
        .memAccess  (memAccess),
        .memRdValid (memRdValid),
        .memRdData  (memRdData),
        .fill       (fill)
    );

    // Refill data goes straight from memory into the cache.
    dataCache u_cache (
        .clk       (clk),
        .rstn      (rstn),
        .lookup    (lookup),
        .cacheReq  (cacheReq),
        .fill      (fill),
        .fillData  (memRdData),
        .cacheHit  (cacheHit),
        .cacheData (cacheData)
    );

    dataMemory u_mem (
        .clk        (clk),
        .rstn       (rstn),
        .memIssue   (memIssue),
        .memAccess  (memAccess),
        .memRdValid (memRdValid),
        .memRdData  (memRdData)
    );

endmodule

/* sim/tbMemSubsystem.sv */
`timescale 1ns/1ps

module tbMemSubsystem;
    import memOpsPkg::*;

    localparam int TIMEOUT_CYCLES = 200;
    localparam string STIM_FILE = "sim/memStimulus.txt";

    logic     clk;
    logic     rstn;
    logic     req;
    memReq_t  reqData;
    logic     ack;
    memResp_t resp;

    int          fd;
    int          code;
    string       line;
    int          tests;
    int          failedTests;
    int          errors;
    int          testErrors;
    bit          aborted;
    logic [1:0]  opVal;
    logic [9:0]  addrVal;
    logic [15:0] wdataVal;
    logic [5:0]  tagVal;
    logic [15:0] expData;
    logic        expHit;

    memSubsystem u_memSubsystem (
        .clk     (clk),
        .rstn    (rstn),
        .req     (req),
        .reqData (reqData),
        .ack     (ack),
        .resp    (resp)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Polls on falling edges until ack reaches level.
    task automatic waitAck(input logic level, output bit reached);
        int cycles;
        cycles = 0;
        while (ack !== level && cycles < TIMEOUT_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        reached = (ack === level);
    endtask

    task automatic reportError(input string msg);
        $display("ERROR at %0t ns: %s", $time, msg);
        testErrors++;
    endtask

    // Tag on every response, data and hit on loads only.
    task automatic checkResponse();
        if (resp.robTag !== tagVal) begin
            reportError($sformatf("addr %03h robTag %02h, expected %02h",
                addrVal, resp.robTag, tagVal));
        end
        if (opVal == OP_LOAD_HALF) begin
            if (resp.rdata !== expData) begin
                reportError($sformatf("load %03h rdata %04h, expected %04h",
                    addrVal, resp.rdata, expData));
            end
            if (resp.hit !== expHit) begin
                reportError($sformatf("load %03h hit %0b, expected %0b",
                    addrVal, resp.hit, expHit));
            end
        end
    endtask

    // One four-phase handshake, req held holdCycles past ack.
    task automatic runTransaction(input int holdCycles);
        bit reached;
        @(negedge clk);
        reqData.op = memOp_e'(opVal);
        reqData.addr = addrVal;
        reqData.wdata = wdataVal;
        reqData.robTag = tagVal;
        req = 1'b1;
        waitAck(1'b1, reached);
        if (!reached) begin
            $display("Timeout: no ack for the request to address %03h", addrVal);
            aborted = 1'b1;
        end else begin
            checkResponse();
            for (int i = 0; i < holdCycles; i++) begin
                @(negedge clk);
                if (ack !== 1'b1) begin
                    reportError("ack fell while req was still held");
                end
            end
            req = 1'b0;
            waitAck(1'b0, reached);
            if (!reached) begin
                $display("Timeout: ack stayed high after req fell at address %03h", addrVal);
                aborted = 1'b1;
            end
        end
    endtask

    initial begin
        req = 1'b0;
        reqData = '0;
        rstn = 1'b0;
        tests = 0;
        failedTests = 0;
        errors = 0;
        aborted = 1'b0;
        repeat (3) @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        if (ack !== 1'b0) begin
            $display("ERROR at %0t ns: ack high after reset", $time);
            errors++;
        end
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file %s", STIM_FILE);
            aborted = 1'b1;
        end
        while (!aborted && !$feof(fd)) begin
            code = $fgets(line, fd);
            if (code == 0 || line.len() < 2 || line[0] == "#") continue; // Comment or blank.
            code = $sscanf(line, "%h %h %h %h %h %h",
                opVal, addrVal, wdataVal, tagVal, expData, expHit);
            if (code != 6) begin
                $display("Malformed stimulus line: %s", line);
                aborted = 1'b1;
                break;
            end
            testErrors = 0;
            runTransaction(tests % 3);
            tests++;
            if (testErrors != 0 || aborted) failedTests++;
            errors += testErrors;
            $display("Test %0d: op %0d addr %03h tag %02h %s", tests, opVal, addrVal,
                tagVal, (testErrors == 0 && !aborted) ? "ok" : "failed");
        end
        if (fd != 0) $fclose(fd);
        $display("Tests run %0d, failed %0d, errors %0d", tests, failedTests, errors);
        if (errors == 0 && failedTests == 0 && !aborted && tests > 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* sim/memStimulus.txt */
# Columns in hex: op addr wdata robTag expData expHit
# op 0 load half, 1 store half, 2 store byte; expData and expHit apply to loads
0 010 0000 01 0000 0
0 010 0000 02 0000 1
1 020 BEEF 03 0000 0
0 020 0000 04 BEEF 0
2 011 005A 05 0000 0
0 010 0000 06 5A00 1
2 020 0011 07 0000 0
0 020 0000 08 BE11 1
1 090 1234 09 0000 0
0 090 0000 0A 1234 0
0 010 0000 0B 5A00 0
0 090 0000 0C 1234 0
0 090 0000 0D 1234 1
1 090 9876 0E 0000 0
0 090 0000 0F 9876 1
1 100 1111 10 0000 0
1 102 2222 11 0000 0
2 105 0033 12 0000 0
1 3FE ABCD 13 0000 0
0 100 0000 14 1111 0
0 102 0000 15 2222 0
0 104 0000 16 3300 0
0 3FE 0000 3F ABCD 0

/* files.f */
design/memGeomPkg.sv
design/memOpsPkg.sv
design/dataCache.sv
design/dataMemory.sv
design/memHierarchyCtrl.sv
design/memSubsystem.sv
sim/tbMemSubsystem.sv

/* Makefile */
VERILATOR ?= verilator
TOP ?= tbMemSubsystem
OBJ_DIR ?= obj_dir
VFLAGS ?= --binary --assert -Wno-fatal
FILELIST ?= files.f

SRCS := $(wildcard design/*.sv) $(wildcard sim/*.sv)
BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(FILELIST) $(SRCS)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	@out=$$(./$(BIN)); echo "$$out"; echo "$$out" | grep -q "Regression passed"

clean:
	rm -rf $(OBJ_DIR)
